//--- test/fp_mul_input.txt
// port a b rm expected_result expected_flags, all hex
// rm one-hot {rtz,rtn,rtp,rna,rne}, flags {nv,dz,of,uf,nx}
0 40000000 40400000 01 40c00000 00
1 c0000000 40400000 08 c0c00000 00
0 c0000000 c0400000 04 40c00000 00
1 40000000 c0400000 10 c0c00000 00
0 40400000 40000000 02 40c00000 00
1 40400000 40000001 01 40c00002 01
0 40400000 40000001 10 40c00001 01
1 c0400000 40000001 04 c0c00001 01
0 c0400000 40000001 08 c0c00002 01
1 7f400000 7f400000 01 7f800000 05
0 7f400000 7f400000 10 7f7fffff 05
1 7f400000 7f400000 08 7f7fffff 05
0 ff400000 7f400000 04 ff7fffff 05
1 ff400000 7f400000 02 ff800000 05
0 7fa00000 3f800000 01 7fc00000 10
1 40000000 7fc12345 08 7fc00000 00
0 7f800000 00000000 02 7fc00000 10
1 80800000 00800000 01 80000000 03
0 80400000 40000000 04 80000000 00

//--- all.f
design/fpu_pkg.sv
design/fp_bus_if.sv
design/fp_classify.sv
design/fp_port_arbiter.sv
design/fp_mul_core.sv
design/fp_edge_checker.sv
design/fp_mul_share_top.sv
test/tb_clock_gen.sv
test/tb_fp_mul_share.sv

//--- test/tb_fp_mul_share.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_mul_share;
    localparam int CLK_PERIOD = 100;
    localparam int MAX_VEC    = 32;
    localparam int FIELDS     = 6;

    logic        clk;
    logic        rst_n;
    logic        p0_req;
    logic [31:0] p0_a;
    logic [31:0] p0_b;
    logic [4:0]  p0_rm;
    logic        p0_busy;
    logic        p0_done;
    logic [31:0] p0_result;
    logic [4:0]  p0_flags;
    logic        p1_req;
    logic [31:0] p1_a;
    logic [31:0] p1_b;
    logic [4:0]  p1_rm;
    logic        p1_busy;
    logic        p1_done;
    logic [31:0] p1_result;
    logic [4:0]  p1_flags;

    // six words per vector: port, a, b, rm, result, flags
    logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int          vec_count;
    logic        loaded;
    int unsigned gap;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.o_clk(clk));

    fp_mul_share_top #(
        .RR_INIT (1'b0)
    ) dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_p0_req    (p0_req),
        .i_p0_a      (p0_a),
        .i_p0_b      (p0_b),
        .i_p0_rm     (p0_rm),
        .o_p0_busy   (p0_busy),
        .o_p0_done   (p0_done),
        .o_p0_result (p0_result),
        .o_p0_flags  (p0_flags),
        .i_p1_req    (p1_req),
        .i_p1_a      (p1_a),
        .i_p1_b      (p1_b),
        .i_p1_rm     (p1_rm),
        .o_p1_busy   (p1_busy),
        .o_p1_done   (p1_done),
        .o_p1_result (p1_result),
        .o_p1_flags  (p1_flags)
    );

    function automatic logic [31:0] vec_field(input int idx, input int f);
        return vec_mem[idx*FIELDS+f];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] t=%0t ns %s got %h expected %h", $time, name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_now(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    // call right after a rising edge, values land on the next edge
    task automatic drive_port(input int port, input int idx);
        logic [31:0] rm_word;
        rm_word = vec_field(idx, 3);
        if (port == 0) begin
            p0_req <= 1'b1;
            p0_a   <= vec_field(idx, 1);
            p0_b   <= vec_field(idx, 2);
            p0_rm  <= rm_word[4:0];
        end else begin
            p1_req <= 1'b1;
            p1_a   <= vec_field(idx, 1);
            p1_b   <= vec_field(idx, 2);
            p1_rm  <= rm_word[4:0];
        end
    endtask

    task automatic check_port_result(input int port, input int idx);
        if (port == 0) begin
            check_value("o_p0_result", p0_result, vec_field(idx, 4));
            check_value("o_p0_flags", 32'(p0_flags), vec_field(idx, 5));
        end else begin
            check_value("o_p1_result", p1_result, vec_field(idx, 4));
            check_value("o_p1_flags", 32'(p1_flags), vec_field(idx, 5));
        end
    endtask

    // entered on the edge where the dut samples the strobe
    task automatic collect(input bit want0, input bit want1, input int idx0, input int idx1,
                           input int max_edges, output int seen0, output int seen1);
        int edges;
        edges = 0;
        seen0 = 0;
        seen1 = 0;
        @(negedge clk);
        if (want0) check_value("o_p0_busy", 32'(p0_busy), 32'd1);
        if (want1) check_value("o_p1_busy", 32'(p1_busy), 32'd1);
        while ((want0 && seen0 == 0) || (want1 && seen1 == 0)) begin
            if (edges >= max_edges) begin
                fail_now($sformatf("no done pulse within %0d cycles of the request", max_edges));
            end else begin
                @(posedge clk);
                edges++;
                @(negedge clk);
                if (p0_done) begin
                    check_value("o_p0_done", 32'(p0_done), 32'(want0));
                    check_port_result(0, idx0);
                    seen0 = edges;
                end
                if (p1_done) begin
                    check_value("o_p1_done", 32'(p1_done), 32'(want1));
                    check_port_result(1, idx1);
                    seen1 = edges;
                end
            end
        end
    endtask

    task automatic run_vectors();
        int port;
        int lat0;
        int lat1;
        for (int i = 0; i < vec_count; i++) begin
            port = vec_field(i, 0);
            gap  = $urandom % 4;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            drive_port(port, i);
            @(posedge clk);
            p0_req <= 1'b0;
            p1_req <= 1'b0;
            collect(port == 0, port == 1, i, i, 3, lat0, lat1);
            // uncontested latency is three cycles
            if (port == 0)
                check_value("o_p0_done latency", lat0, 3);
            else
                check_value("o_p1_done latency", lat1, 3);
        end
    endtask

    // first vector of each port, both strobed on the same edge
    task automatic run_parallel();
        int first0;
        int first1;
        int lat0;
        int lat1;
        first0 = -1;
        first1 = -1;
        for (int i = vec_count - 1; i >= 0; i--) begin
            if (vec_field(i, 0) == 0)
                first0 = i;
            else
                first1 = i;
        end
        if (first0 < 0 || first1 < 0) begin
            fail_now("the vector file needs at least one vector for each port");
        end else begin
            @(posedge clk);
            drive_port(0, first0);
            drive_port(1, first1);
            @(posedge clk);
            p0_req <= 1'b0;
            p1_req <= 1'b0;
            // the losing port waits one extra cycle
            collect(1'b1, 1'b1, first0, first1, 4, lat0, lat1);
            // the port that issued last gave up priority to the other one
            if (vec_field(vec_count - 1, 0) == 0) begin
                check_value("o_p1_done latency", lat1, 3);
                check_value("o_p0_done latency", lat0, 4);
            end else begin
                check_value("o_p0_done latency", lat0, 3);
                check_value("o_p1_done latency", lat1, 4);
            end
            check_value("o_p0_busy", 32'(p0_busy), 32'd0);
            check_value("o_p1_busy", 32'(p1_busy), 32'd0);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        p0_req    = 1'b0;
        p0_a      = '0;
        p0_b      = '0;
        p0_rm     = 5'b00001;
        p1_req    = 1'b0;
        p1_a      = '0;
        p1_b      = '0;
        p1_rm     = 5'b00001;
        vec_count = 0;
        loaded    = 1'b0;
        gap       = $urandom(32'h7965_ab1d);
        // unused words hold a port tag that can never be valid
        for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
            vec_mem[i] = ~32'(i);
        end
        $readmemh("test/fp_mul_input.txt", vec_mem);
        while (vec_count < MAX_VEC && vec_field(vec_count, 0) <= 32'd1) begin
            vec_count++;
        end
        loaded = 1'b1;
        if (vec_count == 0) begin
            fail_now("no vectors found in test/fp_mul_input.txt");
        end else begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            run_vectors();
            run_parallel();
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((vec_count + 4) * 10 * CLK_PERIOD);
        $display("timeout: the test did not finish within %0d clock periods",
                 (vec_count + 4) * 10);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end
endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
endmodule

`default_nettype wire

//--- design/fp_mul_share_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul_share_top #(
    parameter fpu_pkg::port_id_t RR_INIT = '0
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_p0_req,
    input  logic [31:0] i_p0_a,
    input  logic [31:0] i_p0_b,
    input  logic [4:0]  i_p0_rm,
    output logic        o_p0_busy,
    output logic        o_p0_done,
    output logic [31:0] o_p0_result,
    output logic [4:0]  o_p0_flags,
    input  logic        i_p1_req,
    input  logic [31:0] i_p1_a,
    input  logic [31:0] i_p1_b,
    input  logic [4:0]  i_p1_rm,
    output logic        o_p1_busy,
    output logic        o_p1_done,
    output logic [31:0] o_p1_result,
    output logic [4:0]  o_p1_flags
);
    import fpu_pkg::*;

    logic [NUM_PORTS-1:0]       req;
    logic [NUM_PORTS-1:0][31:0] a_vec;
    logic [NUM_PORTS-1:0][31:0] b_vec;
    rm_e  [NUM_PORTS-1:0]       rm_vec;
    logic [NUM_PORTS-1:0]       busy;

    fp_op_if  op_bus ();
    fp_res_if res_bus ();

    assign req       = {i_p1_req, i_p0_req};
    assign a_vec     = {i_p1_a, i_p0_a};
    assign b_vec     = {i_p1_b, i_p0_b};
    assign rm_vec[0] = rm_e'(i_p0_rm);
    assign rm_vec[1] = rm_e'(i_p1_rm);

    assign o_p0_busy = busy[0];
    assign o_p1_busy = busy[1];

    // one shared result bus, done goes to the port named by the tag
    assign o_p0_done   = res_bus.valid && (res_bus.port == port_id_t'(0));
    assign o_p1_done   = res_bus.valid && (res_bus.port == port_id_t'(1));
    assign o_p0_result = res_bus.result;
    assign o_p1_result = res_bus.result;
    assign o_p0_flags  = res_bus.flags;
    assign o_p1_flags  = res_bus.flags;

    fp_port_arbiter #(
        .RR_INIT (RR_INIT)
    ) u_arbiter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (req),
        .i_a     (a_vec),
        .i_b     (b_vec),
        .i_rm    (rm_vec),
        .o_busy  (busy),
        .op      (op_bus)
    );

    fp_mul_core u_core (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .op      (op_bus),
        .res     (res_bus)
    );

    fp_edge_checker u_edge_checker (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .res     (res_bus)
    );

endmodule

`default_nettype wire

//--- design/fp_edge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fp_edge_checker (
    input  logic  i_clk,
    input  logic  i_rst_n,
    fp_res_if.mon res
);
    import fpu_pkg::*;

    logic        r_sign;
    logic [7:0]  r_exp;
    logic [23:0] r_sig;
    fp_class_e   r_class;
    logic        is_inf;
    logic        is_zero;
    logic        is_qnan;
    logic        is_max;
    logic        to_inf;

    fp_classify u_cls_res (
        .i_value (res.result),
        .o_sign  (r_sign),
        .o_exp   (r_exp),
        .o_sig   (r_sig),
        .o_class (r_class)
    );

    assign is_inf  = r_class == INF;
    assign is_zero = r_class == ZERO;
    // only the canonical quiet NaN may leave the core
    assign is_qnan = (r_class == QNAN) && (r_sig[21:0] == '0);
    assign is_max  = (r_exp == FP_POS_MAX[30:23]) && (r_sig == {1'b1, FP_POS_MAX[22:0]});
    // nearest modes and the directed mode pointing away from zero go to infinity
    assign to_inf  = (res.rm == RNE) || (res.rm == RNA) || (res.rm == (r_sign ? RTN : RTP));

    default clocking cb @(posedge i_clk);
    endclocking

    default disable iff (!i_rst_n);

    // multiply alone never divides by zero
    a_no_dz:     assert property (res.valid |-> !res.flags.dz);
    a_nv_qnan:   assert property (res.valid && res.flags.nv |-> is_qnan);
    a_of_nx:     assert property (res.valid && res.flags.of |-> res.flags.nx);
    a_uf_nx:     assert property (res.valid && res.flags.uf |-> res.flags.nx);
    a_uf_zero:   assert property (res.valid && res.flags.uf |-> is_zero);

    // mode and sign pick infinity or the largest finite value on overflow
    a_of_by_rm:  assert property (res.valid && res.flags.of |-> (to_inf ? is_inf : is_max));

    // an infinity that did not overflow is exact
    a_inf_exact: assert property (res.valid && is_inf && !res.flags.of |-> !res.flags.nx);

endmodule

`default_nettype wire

//--- design/fp_mul_core.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul_core (
    input  logic  i_clk,
    input  logic  i_rst_n,
    fp_op_if.snk  op,
    fp_res_if.src res
);
    import fpu_pkg::*;

    logic        a_sign;
    logic        b_sign;
    logic [7:0]  a_exp;
    logic [7:0]  b_exp;
    logic [23:0] a_sig;
    logic [23:0] b_sig;
    fp_class_e   a_class;
    fp_class_e   b_class;
    logic        a_zero, b_zero;
    logic        a_inf, b_inf;
    logic        a_nan, b_nan;
    logic        inv_op;

    // stage 1 registers
    logic              s1_valid;
    rm_e               s1_rm;
    port_id_t          s1_port;
    logic              s1_sign;
    logic signed [9:0] s1_exp;
    logic [47:0]       s1_prod;
    logic              s1_nan;
    logic              s1_nv;
    logic              s1_inf;
    logic              s1_zero;

    // stage 2 datapath
    logic              norm_hi;
    logic [22:0]       mant;
    logic              guard;
    logic              sticky;
    logic              round_up;
    logic [23:0]       mant_r;
    logic signed [9:0] exp_r;
    logic [31:0]       result_d;
    fp_flags_t         flags_d;

    fp_classify u_cls_a (
        .i_value (op.a),
        .o_sign  (a_sign),
        .o_exp   (a_exp),
        .o_sig   (a_sig),
        .o_class (a_class)
    );

    fp_classify u_cls_b (
        .i_value (op.b),
        .o_sign  (b_sign),
        .o_exp   (b_exp),
        .o_sig   (b_sig),
        .o_class (b_class)
    );

    // subnormal inputs count as zero
    assign a_zero = (a_class == ZERO) || (a_class == SUBNORM);
    assign b_zero = (b_class == ZERO) || (b_class == SUBNORM);
    assign a_inf  = a_class == INF;
    assign b_inf  = b_class == INF;
    assign a_nan  = (a_class == QNAN) || (a_class == SNAN);
    assign b_nan  = (b_class == QNAN) || (b_class == SNAN);
    assign inv_op = (a_inf && b_zero) || (a_zero && b_inf);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s1_valid  <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            s1_valid  <= op.valid;
            res.valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_rm   <= op.rm;
        s1_port <= op.port;
        s1_sign <= a_sign ^ b_sign;
        s1_exp  <= {2'b00, a_exp} + {2'b00, b_exp} - 10'(EXP_BIAS);
        s1_prod <= a_sig * b_sig;
        s1_nan  <= a_nan || b_nan || inv_op;
        s1_nv   <= (a_class == SNAN) || (b_class == SNAN) || inv_op;
        s1_inf  <= a_inf || b_inf;
        s1_zero <= a_zero || b_zero;
    end

    always_comb begin
        // product of two [1,2) significands lies in [1,4)
        norm_hi = s1_prod[47];
        if (norm_hi) begin
            mant   = s1_prod[46:24];
            guard  = s1_prod[23];
            sticky = |s1_prod[22:0];
        end else begin
            mant   = s1_prod[45:23];
            guard  = s1_prod[22];
            sticky = |s1_prod[21:0];
        end

        case (s1_rm)
            RNE:     round_up = guard && (sticky || mant[0]);
            RNA:     round_up = guard;
            RTP:     round_up = (guard || sticky) && !s1_sign;
            RTN:     round_up = (guard || sticky) && s1_sign;
            default: round_up = 1'b0;
        endcase

        mant_r = {1'b0, mant} + 24'(round_up);
        // carry out of the mantissa bumps the exponent, fraction is already zero then
        exp_r  = s1_exp + 10'(norm_hi) + 10'(mant_r[23]);

        flags_d = '0;
        if (s1_nan) begin
            result_d   = FP_QNAN;
            flags_d.nv = s1_nv;
        end else if (s1_inf) begin
            result_d = {s1_sign, FP_POS_INF[30:0]};
        end else if (s1_zero) begin
            result_d = {s1_sign, 31'd0};
        end else if (exp_r >= 10'sd255) begin
            result_d   = {s1_sign, of_to_inf(s1_rm, s1_sign) ? FP_POS_INF[30:0]
                                                              : FP_POS_MAX[30:0]};
            flags_d.of = 1'b1;
            flags_d.nx = 1'b1;
        end else if (exp_r <= 10'sd0) begin
            // no gradual underflow, tiny results flush to signed zero
            result_d   = {s1_sign, 31'd0};
            flags_d.uf = 1'b1;
            flags_d.nx = 1'b1;
        end else begin
            result_d   = {s1_sign, exp_r[7:0], mant_r[22:0]};
            flags_d.nx = guard || sticky;
        end
    end

    always_ff @(posedge i_clk) begin
        res.result <= result_d;
        res.flags  <= flags_d;
        res.rm     <= s1_rm;
        res.port   <= s1_port;
    end

    // every issued operation leaves the core two edges later with its own tag
    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        op.valid |-> ##2 (res.valid && res.port == $past(op.port, 2)));

endmodule

`default_nettype wire

//--- design/fp_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fp_port_arbiter #(
    parameter fpu_pkg::port_id_t RR_INIT = '0
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic [fpu_pkg::NUM_PORTS-1:0]         i_req,
    input  logic [fpu_pkg::NUM_PORTS-1:0][31:0]   i_a,
    input  logic [fpu_pkg::NUM_PORTS-1:0][31:0]   i_b,
    input  fpu_pkg::rm_e [fpu_pkg::NUM_PORTS-1:0] i_rm,
    output logic [fpu_pkg::NUM_PORTS-1:0]         o_busy,
    fp_op_if.src                                  op
);
    import fpu_pkg::*;

    logic [NUM_PORTS-1:0]       pend;
    logic [NUM_PORTS-1:0][31:0] slot_a;
    logic [NUM_PORTS-1:0][31:0] slot_b;
    rm_e  [NUM_PORTS-1:0]       slot_rm;
    port_id_t                   prio;
    port_id_t                   gnt_id;
    logic [NUM_PORTS-1:0]       gnt;

    assign o_busy = pend;

    // priority port wins a tie, otherwise whichever port is pending
    // (two ports, so the other one is just the inverted tag)
    always_comb begin
        gnt_id      = pend[prio] ? prio : ~prio;
        gnt         = '0;
        gnt[gnt_id] = pend[gnt_id];
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pend     <= '0;
            prio     <= RR_INIT;
            op.valid <= 1'b0;
        end else begin
            pend     <= (pend & ~gnt) | i_req;
            op.valid <= |gnt;
            if (|gnt) begin
                prio <= ~gnt_id;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (i_req[p]) begin
                slot_a[p]  <= i_a[p];
                slot_b[p]  <= i_b[p];
                slot_rm[p] <= i_rm[p];
            end
        end
        op.a    <= slot_a[gnt_id];
        op.b    <= slot_b[gnt_id];
        op.rm   <= slot_rm[gnt_id];
        op.port <= gnt_id;
    end

    // requester may only strobe once its slot has drained
    a_no_req_while_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_req & pend) == '0);

    // both slots full means one issue while the other slot keeps waiting
    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (&pend) |=> op.valid && (pend != '0));

endmodule

`default_nettype wire

//--- design/fp_classify.sv
`timescale 1ns/1ps
`default_nettype none

module fp_classify (
    input  logic [31:0]        i_value,
    output logic               o_sign,
    output logic [7:0]         o_exp,
    output logic [23:0]        o_sig,
    output fpu_pkg::fp_class_e o_class
);
    import fpu_pkg::*;

    logic [22:0] frac;

    assign o_sign = i_value[31];
    assign o_exp  = i_value[30:23];
    assign frac   = i_value[22:0];

    always_comb begin
        if (o_exp == EXP_SPECIAL) begin
            if (frac == '0)
                o_class = INF;
            else if (frac[22])
                o_class = QNAN;
            else
                o_class = SNAN;
        end else if (o_exp == 8'h00) begin
            o_class = (frac == '0) ? ZERO : SUBNORM;
        end else begin
            o_class = NORM;
        end
    end

    // hidden bit only for normal numbers
    assign o_sig = {o_class == NORM, frac};

endmodule

`default_nettype wire

//--- design/fp_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// one multiply issued from the arbiter to the core
interface fp_op_if;
    import fpu_pkg::*;

    logic        valid;
    logic [31:0] a;
    logic [31:0] b;
    rm_e         rm;
    port_id_t    port;

    modport src (output valid, a, b, rm, port);
    modport snk (input valid, a, b, rm, port);
endinterface

// finished result, tagged with the requesting port
interface fp_res_if;
    import fpu_pkg::*;

    logic        valid;
    logic [31:0] result;
    fp_flags_t   flags;
    rm_e         rm;
    port_id_t    port;

    modport src (output valid, result, flags, rm, port);
    modport mon (input valid, result, flags, rm, port);
endinterface

`default_nettype wire

//--- design/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    // one-hot rounding modes, bit order as in the rm field
    typedef enum logic [4:0] {
        RNE = 5'b00001,
        RNA = 5'b00010,
        RTP = 5'b00100,
        RTN = 5'b01000,
        RTZ = 5'b10000
    } rm_e;

    // exception flags, nv sits in the msb
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fp_flags_t;

    typedef enum logic [2:0] {
        ZERO,
        NORM,
        SUBNORM,
        INF,
        QNAN,
        SNAN
    } fp_class_e;

    localparam int          EXP_BIAS    = 127;
    localparam logic [7:0]  EXP_SPECIAL = 8'hff;
    localparam logic [31:0] FP_QNAN     = 32'h7fc00000;
    localparam logic [31:0] FP_POS_INF  = 32'h7f800000;
    localparam logic [31:0] FP_POS_MAX  = 32'h7f7fffff;

    localparam int NUM_PORTS = 2;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

    // overflow goes to infinity unless the mode rounds toward zero for this sign
    function automatic logic of_to_inf(rm_e rm, logic sign);
        return (rm == RNE) || (rm == RNA) || (rm == RTP && !sign) || (rm == RTN && sign);
    endfunction

endpackage

`default_nettype wire
